/* src.f */
common/l2_axi_pkg.sv
common/l2_line_pkg.sv
common/axi_wr_if.sv
common/line_wr_if.sv
write_buffer/write_buffer.sv
write_arbiter/write_arbiter.sv
verilog/l2_write_path.sv
sim/axi_mem_model.sv
sim/tb_l2_write_path.sv

/* sim/tb_l2_write_path.sv */
`timescale 1ns/1ps

module tb_l2_write_path
    import l2_axi_pkg::*;
    import l2_line_pkg::*;
();

    localparam int NUM_TESTS = 6;
    localparam int WORDS     = 1 << OFFSET_WIDTH_DEF;

    logic       clk = 1'b0;
    logic       rstn;
    axi_addr_t  req_addr;
    line_data_t req_line;
    axi_strb_t  req_strb;
    logic       req_valid, req_uncached, req_ok;
    axi_addr_t  m_awaddr;
    axi_len_t   m_awlen;
    axi_strb_t  m_awstrb;
    axi_data_t  m_wdata;
    logic       m_awvalid, m_awready, m_wvalid, m_wready, m_wlast, m_bvalid, m_bready;

    // uncached flag, address, line or word, strobe.
    logic       tbl_unc  [NUM_TESTS] = '{0, 1, 0, 1, 0, 0};
    axi_addr_t  tbl_addr [NUM_TESTS] = '{'h40, 'h84, 'h100, 'h108, 'h200, 'h210};
    axi_strb_t  tbl_strb [NUM_TESTS] = '{'hf, 'h5, 'hf, 'hc, 'hf, 'hf};
    line_data_t tbl_line [NUM_TESTS] = '{
        128'h1003_1003_1002_1002_1001_1001_1000_1000,
        128'ha1b2_c3d4,
        128'h3303_3303_3302_3302_3301_3301_3300_3300,
        128'h4d4c_4b4a,
        128'h5503_5503_5502_5502_5501_5501_5500_5500,
        128'h6603_6603_6602_6602_6601_6601_6600_6600};

    axi_data_t  shadow [256];
    logic       bvalid_at_ok [NUM_TESTS];
    int         pass_cnt = 0;
    int         fail_cnt = 0;
    bit         test_ok = 1'b1;

    l2_write_path #(.offset_width(OFFSET_WIDTH_DEF)) i_dut (.*);
    axi_mem_model i_mem (.*);

    always #5 clk = ~clk;

    initial begin
        #(NUM_TESTS * 200 + 1000);
        $display("run timed out before all writes reached memory");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_data(string name, axi_data_t exp, axi_data_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_len(string name, axi_len_t exp, axi_len_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic end_test(string name);
        $display("test %s %s", name, test_ok ? "passed" : "failed");
        pass_cnt += test_ok;
        fail_cnt += !test_ok;
        test_ok = 1'b1;
    endtask

    // first memory word an entry touches.
    function automatic int first_word(int i);
        if (tbl_unc[i])
            return tbl_addr[i] >> 2;
        return (tbl_addr[i] >> (OFFSET_WIDTH_DEF + 2)) << OFFSET_WIDTH_DEF;
    endfunction

    initial begin
        int       idx;
        axi_len_t exp_len;
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_uncached = 1'b0;
        req_addr     = '0;
        req_line     = '0;
        req_strb     = '0;
        repeat (2) @(posedge clk);
        #1 rstn = 1'b1;
        foreach (shadow[a])
            shadow[a] = i_mem.mem[a];
        @(negedge clk);
        check_flag("m_awvalid", 1'b0, m_awvalid);
        check_flag("m_wvalid", 1'b0, m_wvalid);
        check_flag("m_bready", 1'b0, m_bready);
        check_flag("req_ok", 1'b0, req_ok);
        end_test("reset");
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            #1;
            req_valid    = 1'b1;
            req_uncached = tbl_unc[i];
            req_addr     = tbl_addr[i];
            req_line     = tbl_line[i];
            req_strb     = tbl_strb[i];
            @(negedge clk);
            while (!req_ok) @(negedge clk);
            bvalid_at_ok[i] = m_bvalid;
            idx = first_word(i);
            for (int w = 0; w < (tbl_unc[i] ? 1 : WORDS); w++)
                for (int b = 0; b < 4; b++)
                    if (!tbl_unc[i] || tbl_strb[i][b])
                        shadow[idx + w][8*b +: 8] = tbl_line[i][32*w + 8*b +: 8];
        end
        @(posedge clk);
        #1 req_valid = 1'b0;
        while (i_mem.resp_count < NUM_TESTS) @(negedge clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            exp_len = tbl_unc[i] ? axi_len_t'(0) : axi_len_t'(WORDS - 1);
            check_len("awlen", exp_len, i_mem.awlen_log[i]);
            check_len("wlast beat", exp_len, i_mem.last_log[i]);
            if (tbl_unc[i])
                check_flag("m_bvalid at req_ok", 1'b1, bvalid_at_ok[i]);
            idx = first_word(i);
            for (int w = 0; w < (tbl_unc[i] ? 1 : WORDS); w++)
                check_data($sformatf("mem[%0h]", 4 * (idx + w)),
                           shadow[idx + w], i_mem.mem[idx + w]);
            end_test($sformatf("%0d", i));
        end
        if (i_mem.txn_count != NUM_TESTS) begin
            $display("memory saw %0d transactions for %0d requests", i_mem.txn_count, NUM_TESTS);
            test_ok = 1'b0;
        end
        end_test("transaction count");
        $display("%0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sim/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model
    import l2_axi_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  axi_addr_t m_awaddr,
    input  axi_len_t  m_awlen,
    input  axi_strb_t m_awstrb,
    input  logic      m_awvalid,
    output logic      m_awready,
    input  axi_data_t m_wdata,
    input  logic      m_wvalid,
    output logic      m_wready,
    input  logic      m_wlast,
    output logic      m_bvalid,
    input  logic      m_bready
);

    axi_data_t mem [256];       // word addressed.
    axi_len_t  awlen_log [16];
    axi_len_t  last_log [16];   // beat index that carried wlast.
    int        txn_count = 0;
    int        resp_count = 0;
    int        beat;
    int        aw_wait = 0;
    int        w_wait = 0;
    axi_addr_t addr_q;
    axi_strb_t strb_q;

    // write slave, serviced once per clock edge.
    initial begin
        void'($urandom(32'h688f23c7));
        m_awready = 1'b0;
        m_wready  = 1'b0;
        m_bvalid  = 1'b0;
        for (int i = 0; i < 256; i++)
            mem[i] = (32'(i) << 2) ^ 32'h5a5a_0000; // fill follows the address.
        forever begin
            @(posedge clk);
            if (m_bvalid && m_bready) begin
                m_bvalid <= 1'b0;
                resp_count++;
            end
            if (m_awvalid && m_awready) begin
                addr_q = m_awaddr;
                strb_q = m_awstrb;  // applies to every beat.
                awlen_log[txn_count] = m_awlen;
                txn_count++;
                beat = 0;
                aw_wait = $urandom_range(3, 0);
            end else if (aw_wait > 0) begin
                aw_wait--;
            end
            if (m_wvalid && m_wready) begin
                for (int b = 0; b < 4; b++)
                    if (strb_q[b])
                        mem[8'((addr_q >> 2) + beat)][8*b +: 8] = m_wdata[8*b +: 8];
                if (m_wlast) begin
                    last_log[txn_count-1] = axi_len_t'(beat);
                    m_bvalid <= 1'b1;
                end
                beat++;
                w_wait = $urandom_range(3, 0);
            end else if (w_wait > 0) begin
                w_wait--;
            end
            m_awready <= rstn && (aw_wait == 0);
            m_wready  <= rstn && (w_wait == 0);
        end
    end

endmodule

/* verilog/l2_write_path.sv */
`timescale 1ns/1ps

module l2_write_path
    import l2_axi_pkg::*;
    import l2_line_pkg::*;
#(
    parameter int offset_width = OFFSET_WIDTH_DEF
) (
    input  logic      clk,
    input  logic      rstn,
    // cache side
    input  axi_addr_t req_addr,
    input  logic [line_words(offset_width)*AXI_DATA_W-1:0] req_line,
    input  logic      req_valid,
    input  logic      req_uncached,
    input  axi_strb_t req_strb,
    output logic      req_ok,
    // memory side
    output axi_addr_t m_awaddr,
    output axi_len_t  m_awlen,
    output axi_strb_t m_awstrb,
    output logic      m_awvalid,
    input  logic      m_awready,
    output axi_data_t m_wdata,
    output logic      m_wvalid,
    input  logic      m_wready,
    output logic      m_wlast,
    input  logic      m_bvalid,
    output logic      m_bready
);

    logic wrt_lock;
    logic dma_lock;

    line_wr_if #(.offset_width(offset_width)) line_bus ();
    axi_wr_if wrt_axi ();

    write_arbiter #(.offset_width(offset_width)) i_write_arbiter (
        .clk          (clk),
        .rstn         (rstn),
        .req_addr     (req_addr),
        .req_line     (req_line),
        .req_valid    (req_valid),
        .req_uncached (req_uncached),
        .req_strb     (req_strb),
        .req_ok       (req_ok),
        .line_o       (line_bus.src),
        .wrt_axi      (wrt_axi.slave),
        .wrt_lock     (wrt_lock),
        .dma_lock     (dma_lock),
        .m_awaddr     (m_awaddr),
        .m_awlen      (m_awlen),
        .m_awstrb     (m_awstrb),
        .m_awvalid    (m_awvalid),
        .m_awready    (m_awready),
        .m_wdata      (m_wdata),
        .m_wvalid     (m_wvalid),
        .m_wready     (m_wready),
        .m_wlast      (m_wlast),
        .m_bvalid     (m_bvalid),
        .m_bready     (m_bready)
    );

    write_buffer #(.offset_width(offset_width)) i_write_buffer (
        .clk      (clk),
        .rstn     (rstn),
        .line_i   (line_bus.dst),
        .wrt_axi  (wrt_axi.master),
        .dma_lock (dma_lock),
        .wrt_lock (wrt_lock)
    );

endmodule

/* write_arbiter/write_arbiter.sv */
`timescale 1ns/1ps

module write_arbiter
    import l2_axi_pkg::*;
    import l2_line_pkg::*;
#(
    parameter int offset_width = OFFSET_WIDTH_DEF
) (
    input  logic      clk,
    input  logic      rstn,
    input  axi_addr_t req_addr,
    input  logic [line_words(offset_width)*AXI_DATA_W-1:0] req_line,
    input  logic      req_valid,
    input  logic      req_uncached,
    input  axi_strb_t req_strb,
    output logic      req_ok,
    line_wr_if.src    line_o,
    axi_wr_if.slave   wrt_axi,
    input  logic      wrt_lock,
    output logic      dma_lock,
    output axi_addr_t m_awaddr,
    output axi_len_t  m_awlen,
    output axi_strb_t m_awstrb,
    output logic      m_awvalid,
    input  logic      m_awready,
    output axi_data_t m_wdata,
    output logic      m_wvalid,
    input  logic      m_wready,
    output logic      m_wlast,
    input  logic      m_bvalid,
    output logic      m_bready
);

    typedef enum logic [2:0] {
        IDLE,
        WRT_W,
        DMA_AW,
        DMA_W,
        DMA_R
    } arb_state_t;

    arb_state_t state;
    arb_state_t state_nxt;
    logic       go_dma;

    // uncached waits until the buffer has drained.
    assign go_dma = req_valid && req_uncached && !wrt_lock;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (go_dma) begin
                    state_nxt = DMA_AW;
                end else if (req_valid && !req_uncached) begin
                    state_nxt = WRT_W;
                end
            end
            WRT_W:   if (line_o.addr_ok) state_nxt = IDLE;
            DMA_AW:  if (m_awready) state_nxt = DMA_W;
            DMA_W:   if (m_wready) state_nxt = DMA_R;
            DMA_R:   if (m_bvalid) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign line_o.addr = req_addr;
    assign line_o.line = req_line;

    always_comb begin
        req_ok      = 1'b0;
        dma_lock    = 1'b0;
        line_o.req  = 1'b0;
        // buffer owns the channel by default.
        m_awaddr        = wrt_axi.awaddr;
        m_awlen         = wrt_axi.awlen;
        m_awstrb        = wrt_axi.awstrb;
        m_awvalid       = wrt_axi.awvalid;
        m_wdata         = wrt_axi.wdata;
        m_wvalid        = wrt_axi.wvalid;
        m_wlast         = wrt_axi.wlast;
        m_bready        = wrt_axi.bready;
        wrt_axi.awready = m_awready;
        wrt_axi.wready  = m_wready;
        wrt_axi.bvalid  = m_bvalid;
        case (state)
            IDLE: dma_lock = go_dma; // hold off a burst start in the same cycle.
            WRT_W: begin
                line_o.req = req_valid;
                req_ok     = line_o.addr_ok;
            end
            DMA_AW, DMA_W, DMA_R: begin
                dma_lock        = 1'b1;
                m_awaddr        = req_addr;
                m_awlen         = LEN_SINGLE;
                m_awstrb        = req_strb;
                m_awvalid       = (state == DMA_AW);
                m_wdata         = req_line[AXI_DATA_W-1:0]; // low word only.
                m_wvalid        = (state == DMA_W);
                m_wlast         = (state == DMA_W);
                m_bready        = (state == DMA_R);
                req_ok          = (state == DMA_R) && m_bvalid;
                wrt_axi.awready = 1'b0;
                wrt_axi.wready  = 1'b0;
                wrt_axi.bvalid  = 1'b0;
            end
            default: ;
        endcase
    end

    // the buffer must be idle whenever the uncached path takes the channel.
    a_lock_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        $rose(dma_lock) |-> !wrt_lock);

    a_dma_single_beat: assert property (@(posedge clk) disable iff (!rstn)
        (dma_lock && m_wvalid && m_wready) |-> m_wlast ##1 m_bready);

endmodule

/* write_buffer/write_buffer.sv */
`timescale 1ns/1ps

module write_buffer
    import l2_axi_pkg::*;
    import l2_line_pkg::*;
#(
    parameter int offset_width = OFFSET_WIDTH_DEF
) (
    input  logic     clk,
    input  logic     rstn,
    line_wr_if.dst   line_i,
    axi_wr_if.master wrt_axi,
    input  logic     dma_lock,
    output logic     wrt_lock
);

    localparam int LINE_W = line_words(offset_width) * AXI_DATA_W;
    localparam logic [offset_width-1:0] LAST_BEAT = offset_width'(line_words(offset_width) - 1);

    typedef enum logic [1:0] {
        BUF_EMPTY,
        BUF_AW,
        BUF_W,
        BUF_B
    } buf_state_t;

    buf_state_t              state;
    logic [offset_width-1:0] beat_cnt;
    logic [LINE_W-1:0]       line_q;
    axi_addr_t               base_q;

    // accept only into an empty buffer.
    assign line_i.addr_ok = line_i.req && (state == BUF_EMPTY);
    assign wrt_lock       = (state != BUF_EMPTY);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= BUF_EMPTY;
            beat_cnt <= '0;
        end else begin
            case (state)
                BUF_EMPTY: begin
                    beat_cnt <= '0;
                    if (line_i.addr_ok) state <= BUF_AW;
                end
                BUF_AW: begin
                    if (wrt_axi.awvalid && wrt_axi.awready) state <= BUF_W;
                end
                BUF_W: begin
                    if (wrt_axi.wvalid && wrt_axi.wready) begin
                        if (wrt_axi.wlast) begin
                            state <= BUF_B;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                BUF_B: begin
                    if (wrt_axi.bvalid) state <= BUF_EMPTY; // bready is high here.
                end
                default: state <= BUF_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (line_i.addr_ok) begin
            line_q <= line_i.line;
            base_q <= line_base(line_i.addr, offset_width);
        end
    end

    // burst only starts once the uncached path has let go.
    assign wrt_axi.awvalid = (state == BUF_AW) && !dma_lock;
    assign wrt_axi.awaddr  = base_q;
    assign wrt_axi.awlen   = axi_len_t'(line_words(offset_width) - 1);
    assign wrt_axi.awstrb  = STRB_FULL;

    assign wrt_axi.wvalid  = (state == BUF_W);
    assign wrt_axi.wdata   = line_q[beat_cnt*AXI_DATA_W +: AXI_DATA_W]; // ascending words.
    assign wrt_axi.wlast   = (state == BUF_W) && (beat_cnt == LAST_BEAT);

    assign wrt_axi.bready  = (state == BUF_B);

    // last beat closes the data phase and opens the response wait.
    a_wlast_final: assert property (@(posedge clk) disable iff (!rstn)
        (wrt_axi.wvalid && wrt_axi.wready && wrt_axi.wlast)
            |-> (beat_cnt == LAST_BEAT) ##1 wrt_axi.bready);

    a_accept_empty: assert property (@(posedge clk) disable iff (!rstn)
        line_i.addr_ok |-> (!wrt_lock && !dma_lock) ##1 wrt_lock);

endmodule

/* common/line_wr_if.sv */
`timescale 1ns/1ps

interface line_wr_if
    import l2_axi_pkg::*;
    import l2_line_pkg::*;
#(
    parameter int offset_width = OFFSET_WIDTH_DEF
) ();

    axi_addr_t addr;
    logic [line_words(offset_width)*AXI_DATA_W-1:0] line; // line_data_t at the default.
    logic req;      // level, held until addr_ok.
    logic addr_ok;  // one-cycle accept.

    modport src (output addr, line, req, input addr_ok);
    modport dst (input addr, line, req, output addr_ok);

endinterface

/* common/axi_wr_if.sv */
`timescale 1ns/1ps

interface axi_wr_if
    import l2_axi_pkg::*;
();

    // address channel, strobe travels with the address.
    axi_addr_t awaddr;
    axi_len_t  awlen;
    axi_strb_t awstrb;
    logic      awvalid;
    logic      awready;

    axi_data_t wdata;
    logic      wvalid;
    logic      wready;
    logic      wlast;

    logic      bvalid;
    logic      bready;

    modport master (
        output awaddr, awlen, awstrb, awvalid,
        input  awready,
        output wdata, wvalid, wlast,
        input  wready,
        input  bvalid,
        output bready
    );

    modport slave (
        input  awaddr, awlen, awstrb, awvalid,
        output awready,
        input  wdata, wvalid, wlast,
        output wready,
        output bvalid,
        input  bready
    );

endinterface

/* common/l2_line_pkg.sv */
package l2_line_pkg;

    import l2_axi_pkg::*;

    localparam int OFFSET_WIDTH_DEF = 2;    // 4 words per line.
    localparam int BYTE_OFS_W = $clog2(AXI_STRB_W);

    // line payload at the default geometry, word 0 in the low bits.
    typedef logic [(1 << OFFSET_WIDTH_DEF)*AXI_DATA_W-1:0] line_data_t;

    function automatic int unsigned line_words(int unsigned offset_width);
        return 1 << offset_width;
    endfunction

    // drop word and byte offset.
    function automatic axi_addr_t line_base(axi_addr_t addr, int unsigned offset_width);
        axi_addr_t mask;
        mask = (axi_addr_t'(1) << (offset_width + BYTE_OFS_W)) - 1;
        return addr & ~mask;
    endfunction

endpackage

/* common/l2_axi_pkg.sv */
package l2_axi_pkg;

    // single 32-bit write channel to memory.
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam int AXI_LEN_W  = 8;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t; // byte address.
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [AXI_LEN_W-1:0]  axi_len_t;  // beats minus one.

    // burst encodings, only INCR is issued.
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] BURST_WRAP  = 2'b10;

    localparam axi_strb_t STRB_FULL  = '1;
    localparam axi_len_t  LEN_SINGLE = '0;

endpackage
